// File: Bender.yml
package:
  name: ara_mem_adapter

sources:
  - files:
      - hw/ara_mem_pkg.sv
      - hw/chunk_sequencer.sv
      - hw/chunk_buffer.sv
      - hw/ara_mem_adapter_top.sv
  - target: test
    files:
      - test/ara_mem_adapter_sva.sv
      - test/ara_mem_adapter_tb.sv

// File: build.f
hw/ara_mem_pkg.sv
hw/chunk_sequencer.sv
hw/chunk_buffer.sv
hw/ara_mem_adapter_top.sv
test/ara_mem_adapter_sva.sv
test/ara_mem_adapter_tb.sv

// File: hw/ara_mem_adapter_top.sv
// DDR chunk adapter top, sequencer plus data buffer
// Byteenable and burstcount are not driven, the memory side assumes full single beats
// Core requests are one-cycle pulses, sampled only while busy is low
`timescale 1ns/1ps
`default_nettype none

module ara_mem_adapter_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // Core read request
    input  logic                   rd_req,
    input  ara_mem_pkg::row_t       rd_row,
    input  ara_mem_pkg::chunk_idx_t rd_chunk,
    output logic                   rd_valid,
    output ara_mem_pkg::signs_t     rd_signs,
    output ara_mem_pkg::accums_t    rd_accums,
    // Core write request
    input  logic                   wr_req,
    input  ara_mem_pkg::row_t       wr_row,
    input  ara_mem_pkg::chunk_idx_t wr_chunk,
    input  ara_mem_pkg::signs_t     wr_signs,
    input  ara_mem_pkg::accums_t    wr_accums,
    output logic                   wr_done,
    // Avalon-MM DDR port
    output logic                   ddr_read,
    output logic                   ddr_write,
    output ara_mem_pkg::ddr_addr_t  ddr_address,
    output ara_mem_pkg::ddr_data_t  ddr_writedata,
    input  ara_mem_pkg::ddr_data_t  ddr_readdata,
    input  logic                   ddr_readdatavalid,
    input  logic                   ddr_waitrequest,
    // Status
    output logic                   busy,
    output ara_mem_pkg::stat_t      stat_rd_count,
    output ara_mem_pkg::stat_t      stat_wr_count
);

    // Sequencer to buffer strobes
    logic                  load_wr;
    logic                  capture_sign;
    logic                  capture_accum;
    logic                  sign_phase;
    ara_mem_pkg::beat_idx_t beat_idx;

    chunk_sequencer u_seq (
        .clk               (clk),
        .rst_n             (rst_n),
        .rd_req            (rd_req),
        .rd_row            (rd_row),
        .rd_chunk          (rd_chunk),
        .wr_req            (wr_req),
        .wr_row            (wr_row),
        .wr_chunk          (wr_chunk),
        .ddr_readdatavalid (ddr_readdatavalid),
        .ddr_waitrequest   (ddr_waitrequest),
        .ddr_read          (ddr_read),
        .ddr_write         (ddr_write),
        .ddr_address       (ddr_address),
        .load_wr           (load_wr),
        .capture_sign      (capture_sign),
        .capture_accum     (capture_accum),
        .beat_idx          (beat_idx),
        .sign_phase        (sign_phase),
        .rd_valid          (rd_valid),
        .wr_done           (wr_done),
        .busy              (busy),
        .stat_rd_count     (stat_rd_count),
        .stat_wr_count     (stat_wr_count)
    );

    chunk_buffer u_buf (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_wr       (load_wr),
        .wr_signs      (wr_signs),
        .wr_accums     (wr_accums),
        .sign_phase    (sign_phase),
        .beat_idx      (beat_idx),
        .capture_sign  (capture_sign),
        .capture_accum (capture_accum),
        .ddr_readdata  (ddr_readdata),
        .ddr_writedata (ddr_writedata),
        .rd_signs      (rd_signs),
        .rd_accums     (rd_accums)
    );

endmodule

`default_nettype wire

// File: hw/ara_mem_pkg.sv
// Shared sizes, region bases and vector types for the DDR chunk adapter
// Accumulator chunks sit at a 16-byte stride, so the top 16 bits of beat 3 are padding
// Region bases must stay aligned to the beat size
`default_nettype none

package ara_mem_pkg;

    // ==================================================
    // Engine geometry
    // ==================================================
    localparam int ROWS           = 16;
    localparam int CHUNKS_PER_ROW = 4;
    localparam int CHUNK_BITS     = 16;
    localparam int ACC_WIDTH      = 7;
    localparam int ACCUM_BITS     = CHUNK_BITS * ACC_WIDTH;

    // ==================================================
    // DDR bus and memory layout
    // ==================================================
    localparam int DDR_DATA_WIDTH = 32;
    localparam int DDR_ADDR_WIDTH = 16;
    localparam int BEAT_BYTES     = DDR_DATA_WIDTH / 8;
    // Beats per accumulator chunk, rounded up
    localparam int ACCUM_BEATS    = (ACCUM_BITS + DDR_DATA_WIDTH - 1) / DDR_DATA_WIDTH;
    // Accumulator vector padded out to whole beats
    localparam int ACCUM_PAD_BITS = ACCUM_BEATS * DDR_DATA_WIDTH;
    localparam int SIGN_BYTES     = CHUNK_BITS / 8;
    localparam int ACCUM_STRIDE   = ACCUM_BEATS * BEAT_BYTES;

    // Vector types
    typedef logic [$clog2(ROWS)-1:0]           row_t;
    typedef logic [$clog2(CHUNKS_PER_ROW)-1:0] chunk_idx_t;
    typedef logic [CHUNK_BITS-1:0]             signs_t;
    // Accumulator i in bits 7i upward
    typedef logic [ACCUM_BITS-1:0]             accums_t;
    typedef logic [DDR_DATA_WIDTH-1:0]         ddr_data_t;
    typedef logic [DDR_ADDR_WIDTH-1:0]         ddr_addr_t;
    typedef logic [$clog2(ACCUM_BEATS)-1:0]    beat_idx_t;
    typedef logic [31:0]                       stat_t;

    // Byte bases of the two regions
    localparam ddr_addr_t SIGN_BASE  = 16'h0000;
    localparam ddr_addr_t ACCUM_BASE = 16'h1000;

endpackage

`default_nettype wire

// File: hw/chunk_buffer.sv
// Chunk data buffer between the core and the DDR beats
// Write data is taken once per transaction on load_wr and held until the next one
// Read results hold until the next read overwrites them
`timescale 1ns/1ps
`default_nettype none

module chunk_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load_wr,
    input  ara_mem_pkg::signs_t     wr_signs,
    input  ara_mem_pkg::accums_t    wr_accums,
    input  logic                   sign_phase,
    input  ara_mem_pkg::beat_idx_t  beat_idx,
    input  logic                   capture_sign,
    input  logic                   capture_accum,
    input  ara_mem_pkg::ddr_data_t  ddr_readdata,
    output ara_mem_pkg::ddr_data_t  ddr_writedata,
    output ara_mem_pkg::signs_t     rd_signs,
    output ara_mem_pkg::accums_t    rd_accums
);

    localparam int PAD_BITS  = ara_mem_pkg::ACCUM_PAD_BITS;
    localparam int BEAT_BITS = ara_mem_pkg::DDR_DATA_WIDTH;

    ara_mem_pkg::signs_t  wr_signs_q;
    ara_mem_pkg::accums_t wr_accums_q;
    logic [PAD_BITS-1:0]  wr_pad;
    logic [PAD_BITS-1:0]  rd_asm_q;
    ara_mem_pkg::signs_t  rd_signs_q;

    // ==================================================
    // Write side
    // ==================================================
    always_ff @(posedge clk) begin
        if (load_wr) begin
            wr_signs_q  <= wr_signs;
            wr_accums_q <= wr_accums;
        end
    end

    // Padding bits above the accumulators go out as zero
    assign wr_pad = {{(PAD_BITS - ara_mem_pkg::ACCUM_BITS){1'b0}}, wr_accums_q};

    // Sign beat in the low bits, else the selected accumulator slice
    always_comb begin
        if (sign_phase) begin
            ddr_writedata = {{(BEAT_BITS - ara_mem_pkg::CHUNK_BITS){1'b0}}, wr_signs_q};
        end else begin
            ddr_writedata = wr_pad[beat_idx*BEAT_BITS +: BEAT_BITS];
        end
    end

    // ==================================================
    // Read side
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_signs_q <= '0;
            rd_asm_q   <= '0;
        end else begin
            if (capture_sign) begin
                rd_signs_q <= ddr_readdata[ara_mem_pkg::CHUNK_BITS-1:0];
            end
            // Beat b lands at bit 32b of the assembly register
            if (capture_accum) begin
                rd_asm_q[beat_idx*BEAT_BITS +: BEAT_BITS] <= ddr_readdata;
            end
        end
    end

    assign rd_signs = rd_signs_q;
    // Upper padding bits dropped
    assign rd_accums = rd_asm_q[ara_mem_pkg::ACCUM_BITS-1:0];

endmodule

`default_nettype wire

// File: hw/chunk_sequencer.sv
// Transaction FSM for the DDR chunk adapter
// One transaction at a time, reads win over writes when both arrive in idle
// Requests seen while busy are dropped, not queued
// Expects exactly one readdatavalid beat per accepted read command
`timescale 1ns/1ps
`default_nettype none

module chunk_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rd_req,
    input  ara_mem_pkg::row_t       rd_row,
    input  ara_mem_pkg::chunk_idx_t rd_chunk,
    input  logic                   wr_req,
    input  ara_mem_pkg::row_t       wr_row,
    input  ara_mem_pkg::chunk_idx_t wr_chunk,
    input  logic                   ddr_readdatavalid,
    input  logic                   ddr_waitrequest,
    output logic                   ddr_read,
    output logic                   ddr_write,
    output ara_mem_pkg::ddr_addr_t  ddr_address,
    output logic                   load_wr,
    output logic                   capture_sign,
    output logic                   capture_accum,
    output ara_mem_pkg::beat_idx_t  beat_idx,
    output logic                   sign_phase,
    output logic                   rd_valid,
    output logic                   wr_done,
    output logic                   busy,
    output ara_mem_pkg::stat_t      stat_rd_count,
    output ara_mem_pkg::stat_t      stat_wr_count
);

    typedef enum logic [3:0] {
        IDLE,
        RD_SIGNS_REQ,
        RD_SIGNS_WAIT,
        RD_ACCUMS_REQ,
        RD_ACCUMS_WAIT,
        RD_DONE,
        WR_SIGNS_REQ,
        WR_SIGNS_WAIT,
        WR_ACCUMS_REQ,
        WR_ACCUMS_WAIT,
        WR_DONE
    } state_t;

    state_t state;
    state_t next_state;

    ara_mem_pkg::row_t       act_row;
    ara_mem_pkg::chunk_idx_t act_chunk;
    ara_mem_pkg::ddr_addr_t  chunk_sel;
    ara_mem_pkg::ddr_addr_t  sign_addr;
    ara_mem_pkg::ddr_addr_t  accum_addr;
    logic                    last_beat;
    logic                    take_rd;
    logic                    take_wr;

    // Read has priority in idle
    assign take_rd   = (state == IDLE) && rd_req;
    assign take_wr   = (state == IDLE) && wr_req && !rd_req;
    assign last_beat = (beat_idx == ara_mem_pkg::beat_idx_t'(ara_mem_pkg::ACCUM_BEATS - 1));

    // ==================================================
    // Next state
    // ==================================================
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (take_rd) begin
                    next_state = RD_SIGNS_REQ;
                end else if (take_wr) begin
                    next_state = WR_SIGNS_REQ;
                end
            end
            // Read path, every command waits for its beat
            RD_SIGNS_REQ:   if (!ddr_waitrequest) next_state = RD_SIGNS_WAIT;
            RD_SIGNS_WAIT:  if (ddr_readdatavalid) next_state = RD_ACCUMS_REQ;
            RD_ACCUMS_REQ:  if (!ddr_waitrequest) next_state = RD_ACCUMS_WAIT;
            RD_ACCUMS_WAIT: begin
                if (ddr_readdatavalid) begin
                    next_state = last_beat ? RD_DONE : RD_ACCUMS_REQ;
                end
            end
            RD_DONE:        next_state = IDLE;
            // Write path, one spacer cycle after each accepted beat
            WR_SIGNS_REQ:   if (!ddr_waitrequest) next_state = WR_SIGNS_WAIT;
            WR_SIGNS_WAIT:  next_state = WR_ACCUMS_REQ;
            WR_ACCUMS_REQ:  if (!ddr_waitrequest) next_state = WR_ACCUMS_WAIT;
            WR_ACCUMS_WAIT: next_state = last_beat ? WR_DONE : WR_ACCUMS_REQ;
            WR_DONE:        next_state = IDLE;
            default:        next_state = IDLE;
        endcase
    end

    // State, beat index and statistics
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            beat_idx      <= '0;
            stat_rd_count <= '0;
            stat_wr_count <= '0;
        end else begin
            state <= next_state;
            if (take_rd || take_wr) begin
                beat_idx <= '0;
            end else if ((state == RD_ACCUMS_WAIT && ddr_readdatavalid) ||
                         state == WR_ACCUMS_WAIT) begin
                // Wraps back to zero after the last beat
                beat_idx <= beat_idx + 1'b1;
            end
            if (state == RD_DONE) begin
                stat_rd_count <= stat_rd_count + 1'b1;
            end
            if (state == WR_DONE) begin
                stat_wr_count <= stat_wr_count + 1'b1;
            end
        end
    end

    // Target row and chunk of the active transaction
    always_ff @(posedge clk) begin
        if (take_rd) begin
            act_row   <= rd_row;
            act_chunk <= rd_chunk;
        end else if (take_wr) begin
            act_row   <= wr_row;
            act_chunk <= wr_chunk;
        end
    end

    // ==================================================
    // Address generation
    // ==================================================
    // Chunk index is row * chunks per row + chunk
    assign chunk_sel = ara_mem_pkg::ddr_addr_t'(act_row) *
                       ara_mem_pkg::ddr_addr_t'(ara_mem_pkg::CHUNKS_PER_ROW) +
                       ara_mem_pkg::ddr_addr_t'(act_chunk);
    assign sign_addr = ara_mem_pkg::SIGN_BASE +
                       chunk_sel * ara_mem_pkg::ddr_addr_t'(ara_mem_pkg::SIGN_BYTES);
    assign accum_addr = ara_mem_pkg::ACCUM_BASE +
                        chunk_sel * ara_mem_pkg::ddr_addr_t'(ara_mem_pkg::ACCUM_STRIDE) +
                        ara_mem_pkg::ddr_addr_t'(beat_idx) *
                        ara_mem_pkg::ddr_addr_t'(ara_mem_pkg::BEAT_BYTES);

    // Commands stay up in the REQ states until waitrequest drops
    always_comb begin
        ddr_read    = 1'b0;
        ddr_write   = 1'b0;
        ddr_address = '0;
        case (state)
            RD_SIGNS_REQ: begin
                ddr_read    = 1'b1;
                ddr_address = sign_addr;
            end
            RD_ACCUMS_REQ: begin
                ddr_read    = 1'b1;
                ddr_address = accum_addr;
            end
            WR_SIGNS_REQ: begin
                ddr_write   = 1'b1;
                ddr_address = sign_addr;
            end
            WR_ACCUMS_REQ: begin
                ddr_write   = 1'b1;
                ddr_address = accum_addr;
            end
            default: begin
                ddr_address = '0;
            end
        endcase
    end

    // Strobes to the chunk buffer
    assign load_wr       = take_wr;
    assign capture_sign  = (state == RD_SIGNS_WAIT) && ddr_readdatavalid;
    assign capture_accum = (state == RD_ACCUMS_WAIT) && ddr_readdatavalid;
    assign sign_phase    = (state == WR_SIGNS_REQ) || (state == RD_SIGNS_REQ);

    // Core side status
    assign rd_valid = (state == RD_DONE);
    assign wr_done  = (state == WR_DONE);
    assign busy     = (state != IDLE);

endmodule

`default_nettype wire

// File: test/ara_mem_adapter_sva.sv
// Protocol assertions for the DDR chunk adapter, bound into the top level
// Checked only while out of reset
`timescale 1ns/1ps
`default_nettype none

module ara_mem_adapter_sva (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   ddr_read,
    input logic                   ddr_write,
    input ara_mem_pkg::ddr_addr_t ddr_address,
    input logic                   ddr_readdatavalid,
    input logic                   ddr_waitrequest,
    input logic                   rd_valid,
    input logic                   wr_done,
    input logic                   busy
);

    // Failure tally, read back by the testbench
    int fail_count = 0;

    // Never read and write together
    a_cmd_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(ddr_read && ddr_write))
        else begin
            $error("ddr_read and ddr_write high together");
            fail_count++;
        end

    // Stalled command holds address and type
    a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (ddr_read || ddr_write) && ddr_waitrequest |=>
            $stable(ddr_address) && $stable(ddr_read) && $stable(ddr_write))
        else begin
            $error("command changed under waitrequest");
            fail_count++;
        end

    // Read done only inside a transaction, right after the last beat
    a_rd_done: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |-> busy && $past(ddr_readdatavalid))
        else begin
            $error("rd_valid without a preceding read beat or while idle");
            fail_count++;
        end

    // Write done two cycles after the last accepted write beat
    a_wr_done: assert property (@(posedge clk) disable iff (!rst_n)
        wr_done |-> busy && $past(ddr_write && !ddr_waitrequest, 2))
        else begin
            $error("wr_done without an accepted write beat or while idle");
            fail_count++;
        end

endmodule

bind ara_mem_adapter_top ara_mem_adapter_sva u_sva (.*);

`default_nettype wire

// File: test/ara_mem_adapter_tb.sv
// Testbench for the DDR chunk adapter with a behavioral Avalon-MM memory
// Memory model stalls at random and returns each read beat 1 to 3 cycles late
// Table entries never touch two chunks that share a sign word
`timescale 1ns/1ps
`default_nettype none

module ara_mem_adapter_tb;

    localparam int NUM_TESTS = 13;
    localparam int MEM_WORDS = 16384;
    localparam logic [1:0] OP_WR   = 2'd0;
    localparam logic [1:0] OP_RD   = 2'd1;
    localparam logic [1:0] OP_BOTH = 2'd2;

    typedef struct packed {
        logic [1:0]              op;
        ara_mem_pkg::row_t       row;
        ara_mem_pkg::chunk_idx_t chunk;
        ara_mem_pkg::signs_t     signs;
        ara_mem_pkg::accums_t    accums;
    } entry_t;

    // ==================================================
    // Stimulus table
    // ==================================================
    entry_t stim [NUM_TESTS] = '{
        '{OP_WR,   4'd0,  2'd0, 16'h1234, 112'h0123456789abcdef0123456789ab},
        '{OP_RD,   4'd0,  2'd0, 16'h0000, 112'h0},
        '{OP_WR,   4'd15, 2'd3, 16'hbeef, 112'hfedcba9876543210fedcba987654},
        '{OP_WR,   4'd7,  2'd1, 16'h0f0f, 112'h5555aaaa5555aaaa5555aaaa5555},
        '{OP_RD,   4'd15, 2'd3, 16'h0000, 112'h0},
        '{OP_RD,   4'd7,  2'd1, 16'h0000, 112'h0},
        // Read wins, this write must be dropped
        '{OP_BOTH, 4'd0,  2'd0, 16'hdead, 112'hffffffffffffffffffffffffffff},
        '{OP_RD,   4'd0,  2'd0, 16'h0000, 112'h0},
        '{OP_WR,   4'd3,  2'd2, 16'hc3a5, 112'h000102030405060708090a0b0c0d},
        '{OP_WR,   4'd7,  2'd1, 16'h7e81, 112'h13579bdf02468ace13579bdf0246},
        '{OP_RD,   4'd3,  2'd2, 16'h0000, 112'h0},
        '{OP_RD,   4'd7,  2'd1, 16'h0000, 112'h0},
        '{OP_RD,   4'd15, 2'd3, 16'h0000, 112'h0}
    };

    logic clk;
    logic rst_n;
    logic rd_req;
    logic wr_req;
    logic rd_valid;
    logic wr_done;
    logic ddr_read;
    logic ddr_write;
    logic ddr_readdatavalid;
    logic ddr_waitrequest;
    logic busy;
    ara_mem_pkg::row_t       rd_row;
    ara_mem_pkg::row_t       wr_row;
    ara_mem_pkg::chunk_idx_t rd_chunk;
    ara_mem_pkg::chunk_idx_t wr_chunk;
    ara_mem_pkg::signs_t     wr_signs;
    ara_mem_pkg::signs_t     rd_signs;
    ara_mem_pkg::accums_t    wr_accums;
    ara_mem_pkg::accums_t    rd_accums;
    ara_mem_pkg::ddr_addr_t  ddr_address;
    ara_mem_pkg::ddr_data_t  ddr_writedata;
    ara_mem_pkg::ddr_data_t  ddr_readdata;
    ara_mem_pkg::stat_t      stat_rd_count;
    ara_mem_pkg::stat_t      stat_wr_count;

    // Memory model state
    logic [31:0] mem [MEM_WORDS];
    logic        rd_pending;
    int          rd_delay;
    logic [31:0] pend_data;

    // Reference copy of stored chunks
    ara_mem_pkg::signs_t  exp_signs [64];
    ara_mem_pkg::accums_t exp_accums [64];

    int errors;
    int checks_run;
    int wr_pulses;

    ara_mem_adapter_top DUT (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ==================================================
    // DDR memory model
    // ==================================================
    // All stall and delay draws come from this process
    initial begin
        void'($urandom(32'h2c2243aa));
        forever begin
            @(posedge clk);
            ddr_readdatavalid <= 1'b0;
            if (rd_pending) begin
                if (rd_delay == 1) begin
                    ddr_readdatavalid <= 1'b1;
                    ddr_readdata      <= pend_data;
                    rd_pending        <= 1'b0;
                end else begin
                    rd_delay <= rd_delay - 1;
                end
            end
            // Accepted commands only, waitrequest low this cycle
            if (ddr_read && !ddr_waitrequest) begin
                rd_pending <= 1'b1;
                rd_delay   <= $urandom_range(3, 1);
                pend_data  <= mem[ddr_address >> 2];
            end
            if (ddr_write && !ddr_waitrequest) begin
                mem[ddr_address >> 2] <= ddr_writedata;
            end
            // Stall about one cycle in four
            ddr_waitrequest <= ($urandom_range(3, 0) == 0);
        end
    end

    always @(negedge clk) begin
        if (rst_n && wr_done) begin
            wr_pulses++;
        end
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] want);
        checks_run++;
        if (got !== want) begin
            errors++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, want);
        end
    endtask

    // Beat b of the accumulators padded to 128 bits
    function automatic logic [31:0] accum_beat(input ara_mem_pkg::accums_t a, input int b);
        logic [127:0] pad;
        pad = {16'h0, a};
        return pad[32*b +: 32];
    endfunction

    function automatic string op_name(input logic [1:0] op);
        if (op == OP_WR) begin
            return "write";
        end else if (op == OP_RD) begin
            return "read ";
        end
        return "both ";
    endfunction

    task automatic run_entry(input int i);
        entry_t                 e;
        int                     idx;
        int                     errs_before;
        int                     pulses_before;
        ara_mem_pkg::ddr_addr_t addr;
        e             = stim[i];
        idx           = int'(e.row) * 4 + int'(e.chunk);
        errs_before   = errors;
        pulses_before = wr_pulses;
        @(posedge clk);
        rd_req    <= (e.op != OP_WR);
        wr_req    <= (e.op != OP_RD);
        rd_row    <= e.row;
        rd_chunk  <= e.chunk;
        wr_row    <= e.row;
        wr_chunk  <= e.chunk;
        wr_signs  <= e.signs;
        wr_accums <= e.accums;
        @(posedge clk);
        rd_req <= 1'b0;
        wr_req <= 1'b0;
        // Busy from the cycle after acceptance
        @(negedge clk);
        check_value("busy", busy, 1);
        // Done pulse, bounded by the watchdog
        while (!((e.op == OP_WR) ? wr_done : rd_valid)) begin
            @(negedge clk);
        end
        if (e.op == OP_WR) begin
            exp_signs[idx]  = e.signs;
            exp_accums[idx] = e.accums;
            addr = ara_mem_pkg::SIGN_BASE + 16'(idx * 2);
            check_value("mem sign word", mem[addr >> 2], {16'h0, e.signs});
            for (int b = 0; b < 4; b++) begin
                addr = ara_mem_pkg::ACCUM_BASE + 16'(idx * 16 + b * 4);
                check_value("mem accum beat", mem[addr >> 2], accum_beat(e.accums, b));
            end
        end else begin
            check_value("rd_signs", rd_signs, exp_signs[idx]);
            check_value("rd_accums", rd_accums, exp_accums[idx]);
        end
        @(negedge clk);
        check_value("busy", busy, 0);
        check_value("wr_done pulses", wr_pulses,
                    pulses_before + ((e.op == OP_WR) ? 1 : 0));
        $display("test %2d %s row %2d chunk %0d: %s", i, op_name(e.op), e.row, e.chunk,
                 (errors == errs_before) ? "ok" : "FAILED");
    endtask

    // Watchdog
    initial begin
        repeat (NUM_TESTS * 200 + 10) @(posedge clk);
        $display("ERROR: watchdog expired before all tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int exp_rd;
        int exp_wr;
        errors = 0;
        checks_run = 0;
        wr_pulses = 0;
        exp_rd = 0;
        exp_wr = 0;
        rst_n = 1'b0;
        rd_req = 1'b0;
        wr_req = 1'b0;
        rd_row = '0;
        rd_chunk = '0;
        wr_row = '0;
        wr_chunk = '0;
        wr_signs = '0;
        wr_accums = '0;
        ddr_readdata = '0;
        ddr_readdatavalid = 1'b0;
        ddr_waitrequest = 1'b0;
        rd_pending = 1'b0;
        rd_delay = 0;
        pend_data = '0;
        // Fill pattern over the whole word address
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = (32'(a) * 32'h9e3779b1) ^ 32'h5a5a0000;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("busy", busy, 0);
        check_value("ddr_read", ddr_read, 0);
        check_value("ddr_write", ddr_write, 0);
        check_value("stat_rd_count", stat_rd_count, 0);
        check_value("stat_wr_count", stat_wr_count, 0);
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_entry(i);
            if (stim[i].op == OP_WR) begin
                exp_wr++;
            end else begin
                exp_rd++;
            end
        end
        check_value("stat_rd_count", stat_rd_count, exp_rd);
        check_value("stat_wr_count", stat_wr_count, exp_wr);
        if (DUT.u_sva.fail_count != 0) begin
            errors += DUT.u_sva.fail_count;
            $display("ERROR: %0d protocol assertion failures", DUT.u_sva.fail_count);
        end
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks_run, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
